/* bank_tracker.sv */
module bank_tracker (
  input  logic               clock,
  input  logic               reset,
  input  logic               accept_i,
  input  ddr3_pkg::ddr_cmd_t cmd_i,
  input  ddr3_pkg::bank_t    ba_i,
  input  ddr3_pkg::row_t     adr_i,
  input  ddr3_pkg::bank_t    req_ba_i,
  output logic               bank_open_o,
  output logic               any_open_o
);
  import ddr3_pkg::*;

  localparam int NUM_BANKS = 2 ** DDR_BANK_BITS;

  // one flag per bank, set while a row is active in it
  logic [NUM_BANKS-1:0] open_q;

  // only the open flag matters here, every request opens its own row
  assign bank_open_o = open_q[req_ba_i];
  assign any_open_o = |open_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      open_q <= '0;
    end else if (accept_i) begin
      case (cmd_i)
        CMD_ACTV: begin
          open_q[ba_i] <= 1'b1;
        end

        CMD_READ, CMD_WRIT: begin
          // auto-precharge closes the bank behind the column access
          if (adr_i[A10_BIT]) begin
            open_q[ba_i] <= 1'b0;
          end
        end

        CMD_PREC: begin
          // bit 10 turns it into PRECHARGE-ALL
          if (adr_i[A10_BIT]) begin
            open_q <= '0;
          end else begin
            open_q[ba_i] <= 1'b0;
          end
        end

        default: begin
          // REFRESH and NOOP leave the banks alone
          open_q <= open_q;
        end
      endcase
    end
  end

endmodule

/* cmd_stage.sv */
module cmd_stage (
  input  logic               clock,
  input  logic               reset,
  input  ddr3_pkg::addr_t    mem_wradr_i,
  input  ddr3_pkg::addr_t    mem_rdadr_i,
  input  logic               load_i,
  input  logic               load_sel_i,
  input  ddr3_pkg::ddr_cmd_t load_cmd_i,
  input  logic               load_auto_i,
  input  logic               load_prec_i,
  input  logic               advance_i,
  output ddr3_pkg::bank_t    req_ba_o,
  output logic               ddl_req_o,
  output ddr3_pkg::ddr_cmd_t ddl_cmd_o,
  output ddr3_pkg::bank_t    ddl_ba_o,
  output ddr3_pkg::row_t     ddl_adr_o
);
  import ddr3_pkg::*;

  localparam int BURST_BITS = DDR_COL_BITS - ADDR_COL_BITS;
  localparam int PAD_BITS = DDR_ROW_BITS - DDR_COL_BITS - 1;

  // address split of the selected port
  addr_t sel_adr;
  row_t  sel_row;
  col_t  sel_col;
  row_t  col_word;
  row_t  prea_word;

  // current command on the DDL port, next one, and a parked column command
  // used only behind a PRECHARGE; NOOP marks an empty slot
  ddr_cmd_t cur_cmd;
  ddr_cmd_t nxt_cmd;
  ddr_cmd_t park_cmd;
  row_t     cur_adr;
  row_t     nxt_adr;
  row_t     park_adr;
  // one bank serves the whole sequence
  bank_t    ba_q;

  assign sel_adr = load_sel_i ? mem_wradr_i : mem_rdadr_i;
  assign sel_row = sel_adr[ADDR_BITS-1 -: DDR_ROW_BITS];
  assign req_ba_o = sel_adr[ADDR_COL_BITS +: DDR_BANK_BITS];
  // low column bits are zero for a burst aligned access
  assign sel_col = {sel_adr[ADDR_COL_BITS-1:0], {BURST_BITS{1'b0}}};
  // column word carries auto-precharge in bit 10
  assign col_word = {{PAD_BITS{1'b0}}, load_auto_i, sel_col};
  assign prea_word = row_t'(1) << A10_BIT;

  assign ddl_req_o = (cur_cmd != CMD_NOOP);
  assign ddl_cmd_o = cur_cmd;
  assign ddl_ba_o = ba_q;
  assign ddl_adr_o = cur_adr;

  always_ff @(posedge clock) begin
    if (reset) begin
      cur_cmd <= CMD_NOOP;
      nxt_cmd <= CMD_NOOP;
      park_cmd <= CMD_NOOP;
    end else if (load_i) begin
      park_cmd <= CMD_NOOP;
      if (load_cmd_i == CMD_REFR) begin
        // optional PRECHARGE-ALL, then REFRESH
        cur_cmd <= load_prec_i ? CMD_PREC : CMD_REFR;
        nxt_cmd <= load_prec_i ? CMD_REFR : CMD_NOOP;
      end else if (load_prec_i) begin
        // close the bank, reopen it at the new row, then the column access
        cur_cmd <= CMD_PREC;
        nxt_cmd <= CMD_ACTV;
        park_cmd <= load_cmd_i;
      end else begin
        cur_cmd <= CMD_ACTV;
        nxt_cmd <= load_cmd_i;
      end
    end else if (advance_i) begin
      // shift up, port goes quiet once all slots are empty
      cur_cmd <= nxt_cmd;
      nxt_cmd <= park_cmd;
      park_cmd <= CMD_NOOP;
    end
  end

  // addresses follow the command slots
  always_ff @(posedge clock) begin
    if (load_i) begin
      park_adr <= col_word;
      if (load_cmd_i == CMD_REFR) begin
        ba_q <= '0;
        cur_adr <= load_prec_i ? prea_word : '0;
        nxt_adr <= '0;
      end else if (load_prec_i) begin
        // single bank PRECHARGE, bit 10 clear
        ba_q <= req_ba_o;
        cur_adr <= '0;
        nxt_adr <= sel_row;
      end else begin
        ba_q <= req_ba_o;
        cur_adr <= sel_row;
        nxt_adr <= col_word;
      end
    end else if (advance_i) begin
      cur_adr <= nxt_adr;
      nxt_adr <= park_adr;
    end
  end

endmodule

/* ddr3_pkg.sv */
package ddr3_pkg;

  // geometry of a 1Gb x16 DDR3 device
  localparam int DDR_ROW_BITS = 13;
  localparam int DDR_COL_BITS = 10;
  localparam int DDR_BANK_BITS = 3;

  // request addresses are burst aligned, so the low column bits are not carried
  localparam int ADDR_BITS = 23;
  localparam int ADDR_COL_BITS = ADDR_BITS - DDR_ROW_BITS - DDR_BANK_BITS;

  // address bit 10 selects auto-precharge (READ/WRITE) or all banks (PRECHARGE)
  localparam int A10_BIT = 10;

  // command word as {ras_n, cas_n, we_n}
  typedef logic [2:0] ddr_cmd_t;

  typedef logic [DDR_BANK_BITS-1:0] bank_t;
  // row address, also used as the column word on the DDL address bus
  typedef logic [DDR_ROW_BITS-1:0] row_t;
  typedef logic [DDR_COL_BITS-1:0] col_t;
  // request address, {row, bank, column} from the top down
  typedef logic [ADDR_BITS-1:0] addr_t;

  localparam ddr_cmd_t CMD_NOOP = 3'b111;
  localparam ddr_cmd_t CMD_ACTV = 3'b011;
  localparam ddr_cmd_t CMD_READ = 3'b101;
  localparam ddr_cmd_t CMD_WRIT = 3'b100;
  localparam ddr_cmd_t CMD_PREC = 3'b010;
  localparam ddr_cmd_t CMD_REFR = 3'b001;

  // scheduler states, one step per accepted DDL command
  typedef enum logic [3:0] {
    ST_INIT = 4'b0000,
    ST_IDLE = 4'b0001,
    ST_READ = 4'b0010,
    ST_WRIT = 4'b0011,
    ST_PREC = 4'b0100,
    ST_PREA = 4'b0110,
    ST_ACTV = 4'b0111,
    ST_REFR = 4'b1000
  } sched_state_t;

endpackage

/* ddr3_sched_top.sv */
module ddr3_sched_top #(
  parameter int REFRESH_CYCLES = 780
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               cfg_run_i,

  // write request port
  input  logic               mem_wrreq_i,
  input  logic               mem_wrlst_i,
  input  ddr3_pkg::addr_t    mem_wradr_i,
  output logic               mem_wrack_o,

  // read request port
  input  logic               mem_rdreq_i,
  input  logic               mem_rdlst_i,
  input  ddr3_pkg::addr_t    mem_rdadr_i,
  output logic               mem_rdack_o,

  // DDR data layer port
  input  logic               ddl_rdy_i,
  output logic               ddl_req_o,
  output ddr3_pkg::ddr_cmd_t ddl_cmd_o,
  output ddr3_pkg::bank_t    ddl_ba_o,
  output ddr3_pkg::row_t     ddl_adr_o
);
  import ddr3_pkg::*;

  // state machine to command stage
  logic     load;
  logic     load_sel;
  ddr_cmd_t load_cmd;
  logic     load_auto;
  logic     load_prec;
  logic     advance;

  // status back to the state machine
  bank_t    req_ba;
  logic     bank_open;
  logic     any_open;
  logic     refresh_due;
  logic     refresh_issued;

  // a command leaves the scheduler on this edge
  logic     accept;

  assign accept = ddl_req_o && ddl_rdy_i;

  sched_fsm u_fsm (
    .clock           (clock),
    .reset           (reset),
    .cfg_run_i       (cfg_run_i),
    .mem_wrreq_i     (mem_wrreq_i),
    .mem_wrlst_i     (mem_wrlst_i),
    .mem_rdreq_i     (mem_rdreq_i),
    .mem_rdlst_i     (mem_rdlst_i),
    .ddl_rdy_i       (ddl_rdy_i),
    .refresh_due_i   (refresh_due),
    .bank_open_i     (bank_open),
    .any_open_i      (any_open),
    .mem_wrack_o     (mem_wrack_o),
    .mem_rdack_o     (mem_rdack_o),
    .load_o          (load),
    .load_sel_o      (load_sel),
    .load_cmd_o      (load_cmd),
    .load_auto_o     (load_auto),
    .load_prec_o     (load_prec),
    .advance_o       (advance),
    .refresh_issued_o(refresh_issued)
  );

  refresh_timer #(
    .REFRESH_CYCLES(REFRESH_CYCLES)
  ) u_timer (
    .clock           (clock),
    .reset           (reset),
    .refresh_issued_i(refresh_issued),
    .refresh_due_o   (refresh_due)
  );

  bank_tracker u_banks (
    .clock      (clock),
    .reset      (reset),
    .accept_i   (accept),
    .cmd_i      (ddl_cmd_o),
    .ba_i       (ddl_ba_o),
    .adr_i      (ddl_adr_o),
    .req_ba_i   (req_ba),
    .bank_open_o(bank_open),
    .any_open_o (any_open)
  );

  cmd_stage u_stage (
    .clock      (clock),
    .reset      (reset),
    .mem_wradr_i(mem_wradr_i),
    .mem_rdadr_i(mem_rdadr_i),
    .load_i     (load),
    .load_sel_i (load_sel),
    .load_cmd_i (load_cmd),
    .load_auto_i(load_auto),
    .load_prec_i(load_prec),
    .advance_i  (advance),
    .req_ba_o   (req_ba),
    .ddl_req_o  (ddl_req_o),
    .ddl_cmd_o  (ddl_cmd_o),
    .ddl_ba_o   (ddl_ba_o),
    .ddl_adr_o  (ddl_adr_o)
  );

endmodule

/* filelist.f */
ddr3_pkg.sv
bank_tracker.sv
cmd_stage.sv
refresh_timer.sv
sched_fsm.sv
ddr3_sched_top.sv
sched_asserts.sv
tb_top.sv

/* refresh_timer.sv */
module refresh_timer #(
  parameter int REFRESH_CYCLES = 780
) (
  input  logic clock,
  input  logic reset,
  input  logic refresh_issued_i,
  output logic refresh_due_o
);

  localparam int CNT_BITS = $clog2(REFRESH_CYCLES + 1);

  logic [CNT_BITS-1:0] count;
  logic                due_q;

  assign refresh_due_o = due_q;

  always_ff @(posedge clock) begin
    if (reset || refresh_issued_i) begin
      // reload so due rises REFRESH_CYCLES cycles from here
      count <= CNT_BITS'(REFRESH_CYCLES - 1);
      due_q <= 1'b0;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end else begin
      // sticky until the scheduler reports the REFRESH
      due_q <= 1'b1;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the scheduler testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_top -o sim_tb

./obj_dir/sim_tb | tee sim.log
grep -q '^\*\* PASS \*\*$' sim.log
echo "simulation passed"

/* sched_asserts.sv */
module sched_asserts (
  input logic               clock,
  input logic               reset,
  input logic               ddl_req_i,
  input logic               ddl_rdy_i,
  input ddr3_pkg::ddr_cmd_t ddl_cmd_i,
  input ddr3_pkg::bank_t    ddl_ba_i,
  input ddr3_pkg::row_t     ddl_adr_i,
  input logic               wrack_i,
  input logic               rdack_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // a command waiting for ready keeps all of its fields
  hold_stable: assert property (@(posedge clock) disable iff (reset)
    (ddl_req_i && !ddl_rdy_i) |=>
      (ddl_req_i && $stable(ddl_cmd_i) && $stable(ddl_ba_i) && $stable(ddl_adr_i)))
    else $error("DDL command changed or dropped before it was accepted");

  // acknowledges are single cycle pulses
  wrack_pulse: assert property (@(posedge clock) disable iff (reset)
    wrack_i |=> !wrack_i)
    else $error("write acknowledge held longer than one cycle");

  rdack_pulse: assert property (@(posedge clock) disable iff (reset)
    rdack_i |=> !rdack_i)
    else $error("read acknowledge held longer than one cycle");

  // an ack only comes out of IDLE, so the DDL port was quiet the cycle before
  ack_from_idle: assert property (@(posedge clock) disable iff (reset)
    (wrack_i || rdack_i) |-> !$past(ddl_req_i))
    else $error("acknowledge while an earlier command sequence was still running");

endmodule

bind ddr3_sched_top sched_asserts u_asserts (
  .clock    (clock),
  .reset    (reset),
  .ddl_req_i(ddl_req_o),
  .ddl_rdy_i(ddl_rdy_i),
  .ddl_cmd_i(ddl_cmd_o),
  .ddl_ba_i (ddl_ba_o),
  .ddl_adr_i(ddl_adr_o),
  .wrack_i  (mem_wrack_o),
  .rdack_i  (mem_rdack_o)
);

/* sched_fsm.sv */
module sched_fsm (
  input  logic               clock,
  input  logic               reset,
  input  logic               cfg_run_i,
  input  logic               mem_wrreq_i,
  input  logic               mem_wrlst_i,
  input  logic               mem_rdreq_i,
  input  logic               mem_rdlst_i,
  input  logic               ddl_rdy_i,
  input  logic               refresh_due_i,
  input  logic               bank_open_i,
  input  logic               any_open_i,
  output logic               mem_wrack_o,
  output logic               mem_rdack_o,
  output logic               load_o,
  output logic               load_sel_o,
  output ddr3_pkg::ddr_cmd_t load_cmd_o,
  output logic               load_auto_o,
  output logic               load_prec_o,
  output logic               advance_o,
  output logic               refresh_issued_o
);
  import ddr3_pkg::*;

  sched_state_t state;

  // remembers the column command kind while the row is opened
  logic wr_q;
  logic wrack_q;
  logic rdack_q;

  // decisions taken only in IDLE
  logic idle;
  logic take_ref;
  logic take_wr;
  logic take_rd;
  // a command sequence is in flight, so ddl_req_o is high
  logic busy;

  assign idle = (state == ST_IDLE);
  assign busy = (state != ST_INIT) && (state != ST_IDLE);

  // refresh first, then writes, then reads
  assign take_ref = idle && refresh_due_i;
  assign take_wr = idle && !refresh_due_i && mem_wrreq_i;
  assign take_rd = idle && !refresh_due_i && !mem_wrreq_i && mem_rdreq_i;

  assign load_o = take_ref || take_wr || take_rd;

  // write port wins whenever both are requesting
  assign load_sel_o = mem_wrreq_i;

  always_comb begin
    if (refresh_due_i) begin
      load_cmd_o = CMD_REFR;
    end else if (mem_wrreq_i) begin
      load_cmd_o = CMD_WRIT;
    end else begin
      load_cmd_o = CMD_READ;
    end
  end

  // last flag of the chosen port becomes auto-precharge
  assign load_auto_o = mem_wrreq_i ? mem_wrlst_i : mem_rdlst_i;

  // refresh needs all banks closed; a request needs its own bank closed
  assign load_prec_o = refresh_due_i ? any_open_i : bank_open_i;

  // each accepted command shifts the command stage
  assign advance_o = busy && ddl_rdy_i;

  // timer restarts once the REFRESH itself has gone out
  assign refresh_issued_o = (state == ST_REFR) && ddl_rdy_i;

  assign mem_wrack_o = wrack_q;
  assign mem_rdack_o = rdack_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_INIT;
      wr_q <= 1'b0;
      wrack_q <= 1'b0;
      rdack_q <= 1'b0;
    end else begin
      // acks are single cycle pulses, aligned with the first command
      wrack_q <= take_wr;
      rdack_q <= take_rd;

      case (state)
        ST_INIT: begin
          // wait for the controller to be released
          if (cfg_run_i) begin
            state <= ST_IDLE;
          end
        end

        ST_IDLE: begin
          if (take_ref) begin
            state <= any_open_i ? ST_PREA : ST_REFR;
          end else if (take_wr || take_rd) begin
            wr_q <= take_wr;
            // bank still open from an earlier request, close it first
            state <= bank_open_i ? ST_PREC : ST_ACTV;
          end
        end

        ST_PREC: begin
          if (ddl_rdy_i) begin
            state <= ST_ACTV;
          end
        end

        ST_ACTV: begin
          // row is open, column command is next
          if (ddl_rdy_i) begin
            state <= wr_q ? ST_WRIT : ST_READ;
          end
        end

        ST_PREA: begin
          if (ddl_rdy_i) begin
            state <= ST_REFR;
          end
        end

        ST_READ, ST_WRIT, ST_REFR: begin
          // last command of the sequence
          if (ddl_rdy_i) begin
            state <= ST_IDLE;
          end
        end

        default: begin
          state <= ST_INIT;
        end
      endcase
    end
  end

endmodule

/* sched_golden.txt */
# port last addr count, then count triples of cmd bank adr (addr and triples in hex)
# port W write, R read, P write raised together with the read on the next line
W 1 048d05 2 3 2 0123 4 2 0428
R 1 115aff 2 3 5 0456 5 5 07f8
W 0 6af390 2 3 7 1abc 4 7 0080
R 1 000b81 3 2 7 0000 3 7 0002 5 7 0408
R 0 7ffc00 2 3 0 1fff 5 0 0000
W 0 20003c 3 2 0 0000 3 0 0800 4 0 01e0
P 1 2aa982 2 3 3 0aaa 4 3 0410
R 0 055644 2 3 4 0155 5 4 0220

/* tb_top.sv */
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import ddr3_pkg::*;

  localparam int MAX_LINES = 32;
  localparam int MAX_CMDS = 3;
  localparam logic [31:0] SEED = 32'h1b4d_f454;

  logic     clock;
  logic     reset;
  logic     cfg_run_i;
  logic     mem_wrreq_i;
  logic     mem_wrlst_i;
  addr_t    mem_wradr_i;
  logic     mem_wrack_o;
  logic     mem_rdreq_i;
  logic     mem_rdlst_i;
  addr_t    mem_rdadr_i;
  logic     mem_rdack_o;
  logic     ddl_rdy_i;
  logic     ddl_req_o;
  ddr_cmd_t ddl_cmd_o;
  bank_t    ddl_ba_o;
  row_t     ddl_adr_o;

  // golden table with one entry per request line
  logic [7:0] g_port [MAX_LINES];
  logic       g_last [MAX_LINES];
  addr_t      g_addr [MAX_LINES];
  int         g_count [MAX_LINES];
  ddr_cmd_t   g_cmd [MAX_LINES][MAX_CMDS];
  bank_t      g_ba [MAX_LINES][MAX_CMDS];
  row_t       g_adr [MAX_LINES][MAX_CMDS];
  int         n_lines = 0;
  logic       golden_ready = 1'b0;

  // every accepted DDL command in order
  ddr_cmd_t log_cmd [$];
  bank_t    log_ba [$];
  row_t     log_adr [$];

  int          refresh_seen = 0;
  int          wr_acks = 0;
  int          rd_acks = 0;
  int          errors = 0;
  // open banks as seen from the accepted commands
  logic [7:0]  open_model = '0;
  logic [31:0] rng;
  int          rdy_delay;

  ddr3_sched_top #(
    .REFRESH_CYCLES(300)
  ) dut0 (
    .clock      (clock),
    .reset      (reset),
    .cfg_run_i  (cfg_run_i),
    .mem_wrreq_i(mem_wrreq_i),
    .mem_wrlst_i(mem_wrlst_i),
    .mem_wradr_i(mem_wradr_i),
    .mem_wrack_o(mem_wrack_o),
    .mem_rdreq_i(mem_rdreq_i),
    .mem_rdlst_i(mem_rdlst_i),
    .mem_rdadr_i(mem_rdadr_i),
    .mem_rdack_o(mem_rdack_o),
    .ddl_rdy_i  (ddl_rdy_i),
    .ddl_req_o  (ddl_req_o),
    .ddl_cmd_o  (ddl_cmd_o),
    .ddl_ba_o   (ddl_ba_o),
    .ddl_adr_o  (ddl_adr_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // DDL responder raises ready 0 to 3 cycles after a command shows up
  initial begin
    ddl_rdy_i = 1'b0;
    rng = xorshift32(SEED);
    rdy_delay = int'(rng % 32'd4);
    forever begin
      @(posedge clock);
      #2;
      // a raised ready was taken on this edge
      ddl_rdy_i = 1'b0;
      if (ddl_req_o && !reset) begin
        if (rdy_delay == 0) begin
          ddl_rdy_i = 1'b1;
          rng = xorshift32(rng);
          rdy_delay = int'(rng % 32'd4);
        end else begin
          rdy_delay--;
        end
      end
    end
  end

  // log accepted commands and count acknowledges
  always @(posedge clock) begin
    if (!reset) begin
      if (ddl_req_o && ddl_rdy_i) begin
        log_cmd.push_back(ddl_cmd_o);
        log_ba.push_back(ddl_ba_o);
        log_adr.push_back(ddl_adr_o);
        if (ddl_cmd_o == CMD_REFR) begin
          refresh_seen++;
        end
      end
      if (mem_wrack_o) begin
        wr_acks++;
      end
      if (mem_rdack_o) begin
        rd_acks++;
      end
    end
  end

  initial begin
    wait (golden_ready);
    repeat (40 * n_lines + 2000) @(posedge clock);
    $display("timeout: the scheduler did not finish the request sequence in time");
    $display("** FAIL **");
    $finish;
  end

  task automatic read_golden();
    int          fd;
    int          code;
    int          cnt;
    int          j;
    logic [7:0]  port;
    logic [1023:0] skip_buf;
    logic [31:0] last;
    logic [31:0] addr;
    logic [31:0] c;
    logic [31:0] b;
    logic [31:0] a;
    fd = $fopen("sched_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open sched_golden.txt");
      errors++;
      return;
    end
    code = $fscanf(fd, " %c", port);
    while (code == 1 && n_lines < MAX_LINES) begin
      if (port == "#") begin
        code = $fgets(skip_buf, fd);
      end else begin
        code = $fscanf(fd, "%d %h %d", last, addr, cnt);
        g_port[n_lines] = port;
        g_last[n_lines] = last[0];
        g_addr[n_lines] = addr[ADDR_BITS-1:0];
        g_count[n_lines] = (cnt > MAX_CMDS) ? MAX_CMDS : cnt;
        for (j = 0; j < g_count[n_lines]; j++) begin
          code = $fscanf(fd, "%h %h %h", c, b, a);
          g_cmd[n_lines][j] = c[2:0];
          g_ba[n_lines][j] = b[DDR_BANK_BITS-1:0];
          g_adr[n_lines][j] = a[DDR_ROW_BITS-1:0];
        end
        n_lines++;
      end
      code = $fscanf(fd, " %c", port);
    end
    $fclose(fd);
  endtask

  task automatic apply_to_model(input ddr_cmd_t cmd, input bank_t ba, input row_t adr);
    if (cmd == CMD_ACTV) begin
      open_model[ba] = 1'b1;
    end else if ((cmd == CMD_READ || cmd == CMD_WRIT) && adr[10]) begin
      open_model[ba] = 1'b0;
    end else if (cmd == CMD_PREC && adr[10]) begin
      open_model = '0;
    end else if (cmd == CMD_PREC) begin
      open_model[ba] = 1'b0;
    end
  endtask

  // idx < 0 checks refresh traffic only
  task automatic check_commands(input int idx);
    int       n_exp;
    int       j;
    logic     prea_pending;
    ddr_cmd_t cmd;
    bank_t    ba;
    row_t     adr;
    n_exp = (idx < 0) ? 0 : g_count[idx];
    prea_pending = 1'b0;
    // refresh traffic that went out ahead of the request
    while (log_cmd.size() > 0 &&
           (log_cmd[0] == CMD_REFR || (log_cmd[0] == CMD_PREC && log_adr[0][10]))) begin
      cmd = log_cmd.pop_front();
      ba = log_ba.pop_front();
      adr = log_adr.pop_front();
      if (cmd == CMD_PREC) begin
        assert (open_model != '0) else begin
          errors++;
          $display("PRECHARGE-ALL issued while every bank was already closed");
        end
        prea_pending = 1'b1;
      end else begin
        assert (open_model == '0) else begin
          errors++;
          $display("[ERROR] open_model at REFRESH: got 0x%h expected 0x00", open_model);
        end
        prea_pending = 1'b0;
      end
      apply_to_model(cmd, ba, adr);
    end
    assert (!prea_pending) else begin
      errors++;
      $display("PRECHARGE-ALL was not followed by a REFRESH");
    end
    j = 0;
    while (j < n_exp && log_cmd.size() > 0) begin
      cmd = log_cmd.pop_front();
      ba = log_ba.pop_front();
      adr = log_adr.pop_front();
      assert (cmd == g_cmd[idx][j]) else begin
        errors++;
        $display("[ERROR] ddl_cmd_o: got 0x%h expected 0x%h (request %0d, command %0d)",
                 cmd, g_cmd[idx][j], idx, j);
      end
      assert (ba == g_ba[idx][j]) else begin
        errors++;
        $display("[ERROR] ddl_ba_o: got 0x%h expected 0x%h (request %0d, command %0d)",
                 ba, g_ba[idx][j], idx, j);
      end
      assert (adr == g_adr[idx][j]) else begin
        errors++;
        $display("[ERROR] ddl_adr_o: got 0x%h expected 0x%h (request %0d, command %0d)",
                 adr, g_adr[idx][j], idx, j);
      end
      apply_to_model(cmd, ba, adr);
      j++;
    end
    assert (j == n_exp) else begin
      errors++;
      $display("request %0d ended after %0d of %0d commands", idx, j, n_exp);
    end
    assert (log_cmd.size() == 0) else begin
      errors++;
      $display("%0d unexpected commands after request %0d", log_cmd.size(), idx);
      log_cmd.delete();
      log_ba.delete();
      log_adr.delete();
    end
  endtask

  task automatic serve_request(input int idx);
    logic want_wr;
    logic got;
    want_wr = (g_port[idx] != "R");
    // a read raised together with a write is already on the port
    if (want_wr || !mem_rdreq_i) begin
      #2;
      if (want_wr) begin
        mem_wrreq_i = 1'b1;
        mem_wrlst_i = g_last[idx];
        mem_wradr_i = g_addr[idx];
      end else begin
        mem_rdreq_i = 1'b1;
        mem_rdlst_i = g_last[idx];
        mem_rdadr_i = g_addr[idx];
      end
      if (g_port[idx] == "P" && idx + 1 < n_lines) begin
        mem_rdreq_i = 1'b1;
        mem_rdlst_i = g_last[idx+1];
        mem_rdadr_i = g_addr[idx+1];
      end
    end
    got = 1'b0;
    while (!got) begin
      @(posedge clock);
      assert (!(want_wr ? mem_rdack_o : mem_wrack_o)) else begin
        errors++;
        $display("acknowledge on the wrong port while serving request %0d", idx);
      end
      got = want_wr ? mem_wrack_o : mem_rdack_o;
    end
    #2;
    if (want_wr) begin
      mem_wrreq_i = 1'b0;
    end else begin
      mem_rdreq_i = 1'b0;
    end
    // sequence is over once the DDL request falls
    @(posedge clock);
    while (ddl_req_o) @(posedge clock);
    check_commands(idx);
  endtask

  initial begin
    int i;
    int n_wr;
    int n_rd;
    reset = 1'b1;
    cfg_run_i = 1'b0;
    mem_wrreq_i = 1'b0;
    mem_wrlst_i = 1'b0;
    mem_wradr_i = '0;
    mem_rdreq_i = 1'b0;
    mem_rdlst_i = 1'b0;
    mem_rdadr_i = '0;
    read_golden();
    assert (n_lines > 0) else begin
      errors++;
      $display("no request lines found in sched_golden.txt");
    end
    golden_ready = 1'b1;
    n_wr = 0;
    n_rd = 0;
    for (i = 0; i < n_lines; i++) begin
      if (g_port[i] == "R") begin
        n_rd++;
      end else begin
        n_wr++;
      end
    end
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b0;
    // both ports request while the scheduler is held in INIT
    mem_wrreq_i = 1'b1;
    mem_rdreq_i = 1'b1;
    repeat (10) begin
      @(posedge clock);
      assert (!ddl_req_o && !mem_wrack_o && !mem_rdack_o) else begin
        errors++;
        $display("scheduler active while cfg_run_i is low");
      end
    end
    #2;
    mem_wrreq_i = 1'b0;
    mem_rdreq_i = 1'b0;
    cfg_run_i = 1'b1;
    for (i = 0; i < n_lines; i++) begin
      serve_request(i);
    end
    // idle through two refreshes so that the second one finds every bank closed
    @(posedge clock);
    while (refresh_seen < 2 || ddl_req_o) @(posedge clock);
    check_commands(-1);
    assert (wr_acks == n_wr) else begin
      errors++;
      $display("[ERROR] mem_wrack_o count: got 0x%h expected 0x%h", wr_acks, n_wr);
    end
    assert (rd_acks == n_rd) else begin
      errors++;
      $display("[ERROR] mem_rdack_o count: got 0x%h expected 0x%h", rd_acks, n_rd);
    end
    $display("checks done: %0d errors, %0d requests, %0d refreshes",
             errors, n_lines, refresh_seen);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
